// File: common/pio_cfg_pkg.sv
package pio_cfg_pkg;

  localparam int PIN_COUNT = 8;
  localparam int PIN_W     = $clog2(PIN_COUNT);  // Pin base fields

  localparam int PROG_DEPTH = 32;
  localparam int PC_W       = 5;

  localparam int FIFO_DEPTH = 4;  // Both host FIFOs

  localparam int WORD_W      = 32;
  localparam int SHIFT_CNT_W = $clog2(WORD_W) + 1;  // Counts up to 32 bits

  localparam int DIV_W = 16;

endpackage

// File: common/pio_isa_pkg.sv
package pio_isa_pkg;

  typedef enum logic [2:0] {
    OP_JMP       = 3'd0,
    OP_WAIT      = 3'd1,
    OP_IN        = 3'd2,
    OP_OUT       = 3'd3,
    OP_PUSH_PULL = 3'd4,  // op1[2] selects PULL
    OP_MOV       = 3'd5,
    OP_IRQ       = 3'd6,
    OP_SET       = 3'd7
  } opcode_e;

  typedef enum logic [2:0] {
    COND_ALWAYS   = 3'd0,
    COND_X_ZERO   = 3'd1,
    COND_X_DEC    = 3'd2,  // X nonzero, then decrement
    COND_Y_ZERO   = 3'd3,
    COND_Y_DEC    = 3'd4,
    COND_X_NE_Y   = 3'd5,
    COND_PIN      = 3'd6,
    COND_OSR_DATA = 3'd7   // OSR not yet shifted empty
  } jmp_cond_e;

  typedef enum logic [2:0] {
    SD_PINS    = 3'd0,
    SD_X       = 3'd1,
    SD_Y       = 3'd2,
    SD_NULL    = 3'd3,
    SD_PINDIRS = 3'd4,
    SD_PC      = 3'd5,
    SD_ISR     = 3'd6,
    SD_OSR     = 3'd7
  } src_dst_e;

  typedef enum logic [1:0] {
    MOV_NONE    = 2'd0,
    MOV_INVERT  = 2'd1,
    MOV_REVERSE = 2'd2
  } mov_op_e;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] delay_side;
    logic [2:0] op1;
    logic [4:0] op2;
  } generic_fields_t;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] delay_side;
    logic [2:0] destination;
    mov_op_e    mov_op;
    logic [2:0] mov_source;
  } mov_fields_t;

  // Same 16 bits, MOV splits op2 into operation and source
  typedef union packed {
    generic_fields_t generic;
    mov_fields_t     mov;
  } pio_instr_t;

endpackage

// File: source/pio_fifo.sv
module pio_fifo
  import pio_cfg_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [WORD_W-1:0] in_data,
  input  logic              in_valid,
  output logic              in_ready,
  output logic [WORD_W-1:0] out_data,
  output logic              out_valid,
  input  logic              out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WORD_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_write;
  logic              do_read;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign do_write  = in_valid && in_ready;
  assign do_read   = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wraps at any depth
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) count <= CNT_W'(DEPTH));
  assert property (@(posedge clk) disable iff (reset) !out_valid |=> $stable(rd_ptr));

endmodule

// File: source/pio_clock_divider.sv
module pio_clock_divider
  import pio_cfg_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             enable,
  input  logic [DIV_W-1:0] div,
  output logic             tick
);

  logic [DIV_W-1:0] count;   // Cycles left until the next tick
  logic [DIV_W-1:0] period;

  assign period = (div == '0) ? DIV_W'(1) : div;  // 0 behaves as 1
  assign tick   = enable && (count == DIV_W'(1));

  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      count <= '0;
    end else if (count <= DIV_W'(1)) begin
      count <= period;  // Reload on terminal count
    end else begin
      count <= count - 1'b1;
    end
  end

endmodule

// File: machine/pio_decoder.sv
module pio_decoder
  import pio_isa_pkg::*;
(
  input  pio_instr_t instr,
  input  logic [2:0] side_count,
  output opcode_e    opcode,
  output logic [2:0] op1,
  output logic [4:0] op2,
  output logic [4:0] delay,
  output logic [4:0] side_set,
  output mov_op_e    mov_op,
  output logic [2:0] mov_source
);

  logic [4:0] delay_side;
  logic [2:0] delay_bits;  // Low bits left for delay

  assign delay_side = instr.generic.delay_side;
  assign delay_bits = 3'd5 - side_count;

  assign opcode     = instr.generic.opcode;
  assign op1        = instr.generic.op1;
  assign op2        = instr.generic.op2;
  assign mov_op     = instr.mov.mov_op;
  assign mov_source = instr.mov.mov_source;

  // Side-set takes the top bits of the shared field
  assign side_set = delay_side >> delay_bits;
  assign delay    = delay_side & ~(5'h1f << delay_bits);

  always_comb begin
    assert (side_count <= 3'd5) else $error("side_count exceeds the 5-bit field");
  end

endmodule

// File: machine/pio_shift_reg.sv
module pio_shift_reg
  import pio_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   en,
  input  logic                   shift_right,
  input  logic                   load,
  input  logic [WORD_W-1:0]      load_value,
  input  logic                   shift,
  input  logic [4:0]             shift_bits,
  input  logic [WORD_W-1:0]      shift_in,
  input  logic                   count_reset,
  output logic [WORD_W-1:0]      value,
  output logic [WORD_W-1:0]      shift_out,
  output logic [SHIFT_CNT_W-1:0] count
);

  logic [SHIFT_CNT_W-1:0] amount;     // 1 to 32 bits
  logic [WORD_W-1:0]      mask;
  logic [WORD_W-1:0]      shifted;
  logic [SHIFT_CNT_W:0]   count_sum;

  assign amount = (shift_bits == '0) ? SHIFT_CNT_W'(WORD_W) : SHIFT_CNT_W'(shift_bits);
  assign mask   = ~({WORD_W{1'b1}} << amount);

  // Right shift brings new bits in at the top, left shift at the bottom
  assign shifted = shift_right ?
      (value >> amount) | (shift_in << (SHIFT_CNT_W'(WORD_W) - amount)) :
      (value << amount) | (shift_in & mask);
  assign shift_out = shift_right ? (value & mask) :
                                   (value >> (SHIFT_CNT_W'(WORD_W) - amount));

  assign count_sum = count + amount;

  always_ff @(posedge clk) begin
    if (en && load) begin
      value <= load_value;
    end else if (en && shift) begin
      value <= shifted;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (en && load) begin
      count <= count_reset ? '0 : SHIFT_CNT_W'(WORD_W);
    end else if (en && shift) begin
      count <= (count_sum > (SHIFT_CNT_W + 1)'(WORD_W)) ? SHIFT_CNT_W'(WORD_W) :
                                                         count_sum[SHIFT_CNT_W-1:0];
    end
  end

endmodule

// File: machine/pio_machine.sv
module pio_machine
  import pio_isa_pkg::*, pio_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic                 tick,
  input  logic                 prog_we,
  input  logic [PC_W-1:0]      prog_addr,
  input  logic [15:0]          prog_data,
  input  logic [WORD_W-1:0]    pull_data,
  input  logic                 pull_valid,
  output logic                 pull_ready,
  output logic [WORD_W-1:0]    push_data,
  output logic                 push_valid,
  input  logic                 push_ready,
  input  logic [PIN_COUNT-1:0] in_pins,
  output logic [PIN_COUNT-1:0] out_pins,
  output logic [PIN_COUNT-1:0] pin_dirs,
  input  logic [PC_W-1:0]      wrap_target,
  input  logic [PC_W-1:0]      wrap_end,
  input  logic [PIN_W-1:0]     out_base,
  input  logic [PIN_W-1:0]     set_base,
  input  logic [PIN_W-1:0]     in_base,
  input  logic [PIN_W-1:0]     side_base,
  input  logic [3:0]           out_count,
  input  logic [3:0]           set_count,
  input  logic [2:0]           side_count,
  input  logic                 shift_right
);

  logic [15:0]            prog_mem [PROG_DEPTH];
  pio_instr_t             instr;
  logic [PC_W-1:0]        pc;
  logic [WORD_W-1:0]      x_reg;
  logic [WORD_W-1:0]      y_reg;
  logic [4:0]             delay_cnt;
  opcode_e                opcode;
  logic [2:0]             op1;
  logic [4:0]             op2;
  logic [4:0]             delay;
  logic [4:0]             side_set;
  mov_op_e                mov_op;
  logic [2:0]             mov_source;
  logic [WORD_W-1:0]      isr_val;
  logic [WORD_W-1:0]      osr_val;
  logic [WORD_W-1:0]      osr_out;
  logic [SHIFT_CNT_W-1:0] osr_count;
  logic [WORD_W-1:0]      in_window;  // in_pins rotated by in_base
  logic [2:0]             src_sel;
  logic [WORD_W-1:0]      src_val;
  logic [WORD_W-1:0]      new_val;
  logic                   exec_now;
  logic                   advance;
  logic                   waiting;
  logic                   jmp;
  logic [PC_W-1:0]        jmp_target;
  logic                   set_x;
  logic                   set_y;
  logic                   dec_x;
  logic                   dec_y;
  logic                   isr_load;
  logic                   isr_shift;
  logic                   osr_load;
  logic                   osr_shift;
  logic                   osr_count_reset;
  logic                   pins_we;
  logic                   dirs_we;
  logic [PIN_W-1:0]       pin_base;
  logic [3:0]             pin_count;
  logic [PIN_COUNT-1:0]   pins_next;
  logic [PIN_COUNT-1:0]   dirs_next;

  // Writes count bits of data starting at base, wrapping around the pin bus
  function automatic logic [PIN_COUNT-1:0] put_pins(input logic [PIN_COUNT-1:0] old_pins,
                                                    input logic [WORD_W-1:0] data,
                                                    input logic [PIN_W-1:0] base,
                                                    input logic [3:0] count);
    logic [PIN_COUNT-1:0] result;
    result = old_pins;
    for (int i = 0; i < PIN_COUNT; i++) begin
      if (i < int'(count)) begin
        result[(int'(base) + i) % PIN_COUNT] = data[i];
      end
    end
    return result;
  endfunction

  function automatic logic [WORD_W-1:0] mov_apply(input logic [WORD_W-1:0] data,
                                                  input mov_op_e op);
    logic [WORD_W-1:0] result;
    result = data;
    case (op)
      MOV_INVERT: result = ~data;
      MOV_REVERSE: begin
        for (int i = 0; i < WORD_W; i++) begin
          result[i] = data[WORD_W-1-i];
        end
      end
      default: result = data;  // MOV_NONE and the spare code
    endcase
    return result;
  endfunction

  assign instr     = prog_mem[pc];
  assign exec_now  = enable && tick && (delay_cnt == '0);
  assign advance   = exec_now && !waiting;
  assign push_data = isr_val;
  assign src_sel   = (opcode == OP_MOV) ? mov_source : op1;
  assign pin_base  = (opcode == OP_SET) ? set_base : out_base;   // MOV and OUT share out pins
  assign pin_count = (opcode == OP_SET) ? set_count : out_count;

  always_comb begin
    in_window = '0;
    for (int i = 0; i < PIN_COUNT; i++) begin
      in_window[i] = in_pins[(int'(in_base) + i) % PIN_COUNT];
    end
  end

  always_comb begin
    case (src_dst_e'(src_sel))
      SD_PINS: src_val = in_window;
      SD_X:    src_val = x_reg;
      SD_Y:    src_val = y_reg;
      SD_NULL: src_val = '0;
      SD_ISR:  src_val = isr_val;
      SD_OSR:  src_val = osr_val;
      default: src_val = '0;
    endcase
  end

  // Execute the current instruction
  always_comb begin
    waiting         = 1'b0;
    jmp             = 1'b0;
    jmp_target      = op2[PC_W-1:0];
    set_x           = 1'b0;
    set_y           = 1'b0;
    dec_x           = 1'b0;
    dec_y           = 1'b0;
    new_val         = '0;
    isr_load        = 1'b0;
    isr_shift       = 1'b0;
    osr_load        = 1'b0;
    osr_shift       = 1'b0;
    osr_count_reset = 1'b1;
    pins_we         = 1'b0;
    dirs_we         = 1'b0;
    pull_ready      = 1'b0;
    push_valid      = 1'b0;
    if (exec_now) begin
      case (opcode)
        OP_JMP: begin
          case (jmp_cond_e'(op1))
            COND_ALWAYS:   jmp = 1'b1;
            COND_X_ZERO:   jmp = (x_reg == '0);
            COND_X_DEC: begin
              jmp   = (x_reg != '0);
              dec_x = 1'b1;
            end
            COND_Y_ZERO:   jmp = (y_reg == '0);
            COND_Y_DEC: begin
              jmp   = (y_reg != '0);
              dec_y = 1'b1;
            end
            COND_X_NE_Y:   jmp = (x_reg != y_reg);
            COND_PIN:      jmp = in_window[0];
            COND_OSR_DATA: jmp = (osr_count < SHIFT_CNT_W'(WORD_W));
            default:       jmp = 1'b0;
          endcase
        end
        OP_WAIT: waiting = (op1[1:0] == 2'd0) && (in_pins[op2[PIN_W-1:0]] != op1[2]);  // GPIO only
        OP_IN: begin
          isr_shift = 1'b1;
          new_val   = src_val;
        end
        OP_OUT: begin
          osr_shift = 1'b1;
          new_val   = osr_out;
          case (src_dst_e'(op1))
            SD_PINS:    pins_we = 1'b1;
            SD_X:       set_x = 1'b1;
            SD_Y:       set_y = 1'b1;
            SD_PINDIRS: dirs_we = 1'b1;
            SD_PC: begin
              jmp        = 1'b1;
              jmp_target = osr_out[PC_W-1:0];
            end
            default: ;
          endcase
        end
        OP_PUSH_PULL: begin
          if (!op1[2]) begin
            push_valid = push_ready;
            waiting    = op1[0] && !push_ready;
            isr_load   = !waiting;  // ISR clears even when a non-blocking push is dropped
          end else begin
            pull_ready      = pull_valid;
            waiting         = op1[0] && !pull_valid;
            osr_load        = !waiting;
            new_val         = pull_valid ? pull_data : x_reg;
            osr_count_reset = pull_valid;  // X copy leaves OSR marked empty
          end
        end
        OP_MOV: begin
          new_val = mov_apply(src_val, mov_op);
          case (src_dst_e'(op1))
            SD_PINS: pins_we = 1'b1;
            SD_X:    set_x = 1'b1;
            SD_Y:    set_y = 1'b1;
            SD_ISR:  isr_load = 1'b1;
            SD_OSR:  osr_load = 1'b1;
            default: ;
          endcase
        end
        OP_IRQ: ;  // Decoded, no effect
        OP_SET: begin
          new_val = WORD_W'(op2);
          case (src_dst_e'(op1))
            SD_PINS:    pins_we = 1'b1;
            SD_X:       set_x = 1'b1;
            SD_Y:       set_y = 1'b1;
            SD_PINDIRS: dirs_we = 1'b1;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    pins_next = out_pins;
    dirs_next = pin_dirs;
    if (pins_we) begin
      pins_next = put_pins(out_pins, new_val, pin_base, pin_count);
    end
    if (dirs_we) begin
      dirs_next = put_pins(pin_dirs, new_val, pin_base, pin_count);
    end
    if (exec_now) begin  // Side-set wins, also while stalled
      pins_next = put_pins(pins_next, WORD_W'(side_set), side_base, {1'b0, side_count});
    end
  end

  always_ff @(posedge clk) begin
    if (prog_we) begin
      prog_mem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      delay_cnt <= '0;
      out_pins  <= '0;
      pin_dirs  <= '0;
    end else begin
      out_pins <= pins_next;
      pin_dirs <= dirs_next;
      if (enable && tick && delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end else if (advance) begin
        delay_cnt <= delay;
      end
      if (advance) begin
        if (jmp) begin
          pc <= jmp_target;
        end else if (pc == wrap_end) begin
          pc <= wrap_target;
        end else begin
          pc <= pc + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      if (set_x) begin
        x_reg <= new_val;
      end else if (dec_x) begin
        x_reg <= x_reg - 1'b1;
      end
      if (set_y) begin
        y_reg <= new_val;
      end else if (dec_y) begin
        y_reg <= y_reg - 1'b1;
      end
    end
  end

  pio_decoder decoder_i (
    .instr      (instr),
    .side_count (side_count),
    .opcode     (opcode),
    .op1        (op1),
    .op2        (op2),
    .delay      (delay),
    .side_set   (side_set),
    .mov_op     (mov_op),
    .mov_source (mov_source)
  );

  pio_shift_reg isr_i (
    .clk         (clk),
    .reset       (reset),
    .en          (advance),
    .shift_right (shift_right),
    .load        (isr_load),
    .load_value  (new_val),
    .shift       (isr_shift),
    .shift_bits  (op2),
    .shift_in    (new_val),
    .count_reset (1'b1),
    .value       (isr_val),
    .shift_out   (),
    .count       ()
  );

  pio_shift_reg osr_i (
    .clk         (clk),
    .reset       (reset),
    .en          (advance),
    .shift_right (shift_right),
    .load        (osr_load),
    .load_value  (new_val),
    .shift       (osr_shift),
    .shift_bits  (op2),
    .shift_in    ('0),
    .count_reset (osr_count_reset),
    .value       (osr_val),
    .shift_out   (osr_out),
    .count       (osr_count)
  );

  // FIFO strobes only fire when the partner side is already there
  assert property (@(posedge clk) disable iff (reset) push_valid |-> push_ready);
  assert property (@(posedge clk) disable iff (reset) pull_ready |-> pull_valid);
  assert property (@(posedge clk) disable iff (reset) enable |-> !prog_we);

endmodule

// File: source/pio_top.sv
module pio_top
  import pio_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic [DIV_W-1:0]     clk_div,
  input  logic                 prog_we,
  input  logic [PC_W-1:0]      prog_addr,
  input  logic [15:0]          prog_data,
  input  logic [WORD_W-1:0]    tx_data,
  input  logic                 tx_valid,
  output logic                 tx_ready,
  output logic [WORD_W-1:0]    rx_data,
  output logic                 rx_valid,
  input  logic                 rx_ready,
  input  logic [PIN_COUNT-1:0] in_pins,
  output logic [PIN_COUNT-1:0] out_pins,
  output logic [PIN_COUNT-1:0] pin_dirs,
  input  logic [PC_W-1:0]      wrap_target,
  input  logic [PC_W-1:0]      wrap_end,
  input  logic [PIN_W-1:0]     out_base,
  input  logic [PIN_W-1:0]     set_base,
  input  logic [PIN_W-1:0]     in_base,
  input  logic [PIN_W-1:0]     side_base,
  input  logic [3:0]           out_count,
  input  logic [3:0]           set_count,
  input  logic [2:0]           side_count,
  input  logic                 shift_right
);

  logic [WORD_W-1:0] pull_data;
  logic              pull_valid;
  logic              pull_ready;
  logic [WORD_W-1:0] push_data;
  logic              push_valid;
  logic              push_ready;
  logic              tick;

  pio_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo_i (  // Host to machine
    .clk       (clk),
    .reset     (reset),
    .in_data   (tx_data),
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .out_data  (pull_data),
    .out_valid (pull_valid),
    .out_ready (pull_ready)
  );

  pio_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo_i (  // Machine to host
    .clk       (clk),
    .reset     (reset),
    .in_data   (push_data),
    .in_valid  (push_valid),
    .in_ready  (push_ready),
    .out_data  (rx_data),
    .out_valid (rx_valid),
    .out_ready (rx_ready)
  );

  pio_clock_divider divider_i (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .div    (clk_div),
    .tick   (tick)
  );

  pio_machine machine_i (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .tick        (tick),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .pull_data   (pull_data),
    .pull_valid  (pull_valid),
    .pull_ready  (pull_ready),
    .push_data   (push_data),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .in_pins     (in_pins),
    .out_pins    (out_pins),
    .pin_dirs    (pin_dirs),
    .wrap_target (wrap_target),
    .wrap_end    (wrap_end),
    .out_base    (out_base),
    .set_base    (set_base),
    .in_base     (in_base),
    .side_base   (side_base),
    .out_count   (out_count),
    .set_count   (set_count),
    .side_count  (side_count),
    .shift_right (shift_right)
  );

endmodule

// File: sim/pio_top_tb.sv
module pio_top_tb
  import pio_isa_pkg::*, pio_cfg_pkg::*;
();

  localparam int DRIVE_DELAY    = 5;
  localparam int TIMEOUT_CYCLES = 1000;
  localparam int STUCK_CYCLES   = 32;  // Longer than one pass of the program
  localparam int PROG_INVERT    = 0;
  localparam int PROG_REVERSE   = 1;
  localparam int PROG_SHIFT     = 2;
  localparam int PROG_SET       = 3;
  localparam int PROG_WAIT      = 4;
  localparam int PROG_FLOW      = 5;  // Invert program under back-pressure
  localparam logic [2:0] PUSH_BLOCK = 3'b001;
  localparam logic [2:0] PULL_BLOCK = 3'b101;
  localparam logic [2:0] WAIT_GPIO_HIGH = 3'b100;
  localparam logic [PIN_W-1:0] SET_BASE = PIN_W'(2);

  logic                 clk;
  logic                 reset;
  logic                 enable;
  logic [DIV_W-1:0]     clk_div;
  logic                 prog_we;
  logic [PC_W-1:0]      prog_addr;
  logic [15:0]          prog_data;
  logic [WORD_W-1:0]    tx_data;
  logic                 tx_valid;
  logic                 tx_ready;
  logic [WORD_W-1:0]    rx_data;
  logic                 rx_valid;
  logic                 rx_ready;
  logic [PIN_COUNT-1:0] in_pins;
  logic [PIN_COUNT-1:0] out_pins;
  logic [PIN_COUNT-1:0] pin_dirs;
  logic [PC_W-1:0]      wrap_target;
  logic [PC_W-1:0]      wrap_end;
  logic [PIN_W-1:0]     out_base;
  logic [PIN_W-1:0]     set_base;
  logic [PIN_W-1:0]     in_base;
  logic [PIN_W-1:0]     side_base;
  logic [3:0]           out_count;
  logic [3:0]           set_count;
  logic [2:0]           side_count;
  logic                 shift_right;

  int                   seed;
  int                   row_prog[$];
  logic [WORD_W-1:0]    row_tx[$];
  logic [PIN_COUNT-1:0] row_pins[$];
  logic [WORD_W-1:0]    row_expect[$];
  logic                 set_prev;
  int                   set_edges;  // Rising edges on the SET pin since reset

  pio_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      set_prev  <= 1'b0;
      set_edges <= 0;
    end else begin
      set_prev <= out_pins[SET_BASE];
      if (out_pins[SET_BASE] && !set_prev) begin
        set_edges <= set_edges + 1;
      end
    end
  end

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h",
                              $time, name, got, expected));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  function automatic logic [15:0] asm_op(input opcode_e op, input logic [2:0] op1,
                                         input logic [4:0] op2);
    pio_instr_t instr;
    instr.generic.opcode     = op;
    instr.generic.delay_side = 5'd0;
    instr.generic.op1        = op1;
    instr.generic.op2        = op2;
    return instr;
  endfunction

  function automatic logic [15:0] asm_mov(input src_dst_e dst, input mov_op_e op,
                                          input src_dst_e src);
    pio_instr_t instr;
    instr.mov.opcode      = OP_MOV;
    instr.mov.delay_side  = 5'd0;
    instr.mov.destination = dst;
    instr.mov.mov_op      = op;
    instr.mov.mov_source  = src;
    return instr;
  endfunction

  function automatic logic [31:0] reverse_word(input logic [31:0] word);
    logic [31:0] result;
    for (int i = 0; i < 32; i++) begin
      result[31-i] = word[i];
    end
    return result;
  endfunction

  function automatic logic [31:0] expected_for(input int sel, input logic [31:0] tx,
                                               input logic [PIN_COUNT-1:0] pins);
    case (sel)
      PROG_REVERSE: return reverse_word(tx);
      PROG_SHIFT:   return {tx[31:24], 24'h0};  // Top byte out, back in, then 24 zeros
      PROG_SET:     return tx + 32'd1;          // X-- loop runs X+1 times
      PROG_WAIT:    return 32'(pins);
      default:      return ~tx;
    endcase
  endfunction

  task automatic add_row(input int sel, input logic [31:0] tx,
                         input logic [PIN_COUNT-1:0] pins);
    row_prog.push_back(sel);
    row_tx.push_back(tx);
    row_pins.push_back(pins);
    row_expect.push_back(expected_for(sel, tx, pins));
  endtask

  task automatic apply_reset();
    reset    = 1'b1;
    enable   = 1'b0;
    prog_we  = 1'b0;
    tx_valid = 1'b0;
    rx_ready = 1'b0;
    repeat (16) next_cycle();
    reset = 1'b0;
  endtask

  task automatic load_program(input int sel);
    logic [15:0] prog[$];
    case (sel)
      PROG_SHIFT: begin
        prog.push_back(asm_op(OP_PUSH_PULL, PULL_BLOCK, 5'd0));
        prog.push_back(asm_op(OP_OUT, SD_X, 5'd8));
        prog.push_back(asm_op(OP_IN, SD_X, 5'd8));
        prog.push_back(asm_op(OP_IN, SD_NULL, 5'd24));
        prog.push_back(asm_op(OP_PUSH_PULL, PUSH_BLOCK, 5'd0));
      end
      PROG_SET: begin
        prog.push_back(asm_op(OP_PUSH_PULL, PULL_BLOCK, 5'd0));
        prog.push_back(asm_op(OP_OUT, SD_X, 5'd0));  // 0 means all 32 bits
        prog.push_back(asm_op(OP_SET, SD_PINS, 5'd1));
        prog.push_back(asm_op(OP_SET, SD_PINS, 5'd0));
        prog.push_back(asm_op(OP_JMP, COND_X_DEC, 5'd2));
        prog.push_back(asm_op(OP_PUSH_PULL, PUSH_BLOCK, 5'd0));
      end
      PROG_WAIT: begin
        prog.push_back(asm_op(OP_WAIT, WAIT_GPIO_HIGH, 5'd0));
        prog.push_back(asm_mov(SD_ISR, MOV_NONE, SD_PINS));
        prog.push_back(asm_op(OP_PUSH_PULL, PUSH_BLOCK, 5'd0));
      end
      default: begin
        prog.push_back(asm_op(OP_PUSH_PULL, PULL_BLOCK, 5'd0));
        prog.push_back(asm_mov(SD_X, (sel == PROG_REVERSE) ? MOV_REVERSE : MOV_INVERT,
                               SD_OSR));
        prog.push_back(asm_mov(SD_ISR, MOV_NONE, SD_X));
        prog.push_back(asm_op(OP_PUSH_PULL, PUSH_BLOCK, 5'd0));
      end
    endcase
    enable = 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      prog_we   = 1'b1;
      prog_addr = PC_W'(i);
      prog_data = prog[i];
      next_cycle();
    end
    prog_we     = 1'b0;
    wrap_target = '0;
    wrap_end    = PC_W'(prog.size() - 1);
    clk_div     = DIV_W'(2);
    enable      = 1'b1;
  endtask

  task automatic send_word(input logic [31:0] word);
    int cycles;
    cycles   = 0;
    tx_data  = word;
    tx_valid = 1'b1;
    while (!tx_ready) begin
      next_cycle();
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_on_error("Timed out waiting for tx_ready to accept a word");
      end
    end
    next_cycle();  // Accepted at this edge
    tx_valid = 1'b0;
  endtask

  task automatic receive_word(output logic [31:0] word);
    int cycles;
    cycles = 0;
    while (!rx_valid) begin
      next_cycle();
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_on_error("Timed out waiting for rx_valid");
      end
    end
    word     = rx_data;
    rx_ready = 1'b1;
    next_cycle();
    rx_ready = 1'b0;
  endtask

  task automatic run_word_row(input logic [31:0] tx, input logic [31:0] expected);
    logic [31:0] got;
    send_word(tx);
    receive_word(got);
    check_value("rx_data", got, expected);
  endtask

  task automatic run_set_row(input logic [31:0] tx, input logic [31:0] expected);
    logic [31:0] got;
    send_word(tx);
    receive_word(got);  // PUSH marks the end of the loop
    check_value("out_pins set_base rising edges", 32'(set_edges), expected);
  endtask

  task automatic run_wait_row(input logic [PIN_COUNT-1:0] pins, input logic [31:0] expected);
    logic [31:0] got;
    in_pins = pins & ~PIN_COUNT'(1);
    repeat (40) begin
      next_cycle();
      check_value("rx_valid", 32'(rx_valid), 32'd0);
    end
    in_pins = pins;
    receive_word(got);
    check_value("rx_data", got, expected);
  endtask

  task automatic run_flow_row(input logic [31:0] first);
    logic [31:0] sent[$];
    logic [31:0] word;
    logic [31:0] got;
    int          idle;
    word     = first;
    idle     = 0;
    rx_ready = 1'b0;
    tx_data  = word;
    tx_valid = 1'b1;
    while (idle < STUCK_CYCLES) begin  // Offer words until tx_ready stays low
      if (tx_ready) begin
        if (sent.size() == 2 * FIFO_DEPTH + 2) begin
          stop_on_error("tx_ready stayed high with the receive side blocked");
        end
        next_cycle();
        sent.push_back(word);
        word    = $random(seed);
        tx_data = word;
        idle    = 0;
      end else begin
        next_cycle();
        idle++;
      end
    end
    tx_valid = 1'b0;
    for (int i = 0; i < sent.size(); i++) begin
      receive_word(got);
      check_value("rx_data", got, ~sent[i]);
    end
  endtask

  initial begin
    seed        = 64;
    reset       = 1'b1;
    enable      = 1'b0;
    clk_div     = DIV_W'(2);
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    tx_data     = '0;
    tx_valid    = 1'b0;
    rx_ready    = 1'b0;
    in_pins     = '0;
    wrap_target = '0;
    wrap_end    = '0;
    out_base    = '0;
    set_base    = SET_BASE;
    in_base     = '0;
    side_base   = '0;
    out_count   = 4'd8;
    set_count   = 4'd1;
    side_count  = 3'd0;  // No side-set, all five bits are delay
    shift_right = 1'b0;

    add_row(PROG_INVERT, $random(seed), '0);
    add_row(PROG_INVERT, $random(seed), '0);
    add_row(PROG_REVERSE, $random(seed), '0);
    add_row(PROG_REVERSE, $random(seed), '0);
    add_row(PROG_SHIFT, $random(seed), '0);
    add_row(PROG_SHIFT, $random(seed), '0);
    add_row(PROG_SET, $random(seed) & 32'h7, '0);  // Small loop counts
    add_row(PROG_SET, $random(seed) & 32'h7, '0);
    add_row(PROG_WAIT, '0, PIN_COUNT'($random(seed)) | PIN_COUNT'(1));
    add_row(PROG_FLOW, $random(seed), '0);

    apply_reset();
    check_value("rx_valid", 32'(rx_valid), 32'd0);
    check_value("tx_ready", 32'(tx_ready), 32'd1);
    check_value("out_pins", 32'(out_pins), 32'd0);
    check_value("pin_dirs", 32'(pin_dirs), 32'd0);

    for (int r = 0; r < row_prog.size(); r++) begin
      apply_reset();  // Clears the PC and both FIFOs between programs
      load_program(row_prog[r]);
      case (row_prog[r])
        PROG_SET:  run_set_row(row_tx[r], row_expect[r]);
        PROG_WAIT: run_wait_row(row_pins[r], row_expect[r]);
        PROG_FLOW: run_flow_row(row_tx[r]);
        default:   run_word_row(row_tx[r], row_expect[r]);
      endcase
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: pio_top.f
common/pio_cfg_pkg.sv
common/pio_isa_pkg.sv
source/pio_fifo.sv
source/pio_clock_divider.sv
machine/pio_decoder.sv
machine/pio_shift_reg.sv
machine/pio_machine.sv
source/pio_top.sv
sim/pio_top_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module pio_top_tb -f pio_top.f &&
./obj_dir/Vpio_top_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
